/* flist.f */
vaddr_pkg.sv
addr_queue.sv
burst_splitter.sv
vmem_addrgen.sv
tb_vmem_addrgen.sv

/* Bender.yml */
package:
  name: vmem_addrgen

sources:
  - vaddr_pkg.sv
  - addr_queue.sv
  - burst_splitter.sv
  - vmem_addrgen.sv
  - target: test
    files:
      - tb_vmem_addrgen.sv

/* tb_vmem_addrgen.sv */
// Testbench for the vector memory address generator with a burst reference model
`timescale 1ns/1ps
`default_nettype none

module tb_vmem_addrgen;

  localparam int unsigned AxiDataWidth = 64;
  localparam int unsigned QueueDepth   = 4;
  localparam int          BeatBytes    = AxiDataWidth / 8;
  localparam int          WaitLimit    = 3000;

  logic                 clk;
  logic                 rst_n;
  vaddr_pkg::vmem_req_t req;
  logic                 req_valid, ack, err;
  vaddr_pkg::axi_ax_t   ar, aw, beat;
  logic                 ar_valid, ar_ready, aw_valid, aw_ready;
  vaddr_pkg::lsu_req_t  lsu_req;
  logic                 lsu_valid, ldu_ready, stu_ready, lsu_hold;

  // Predicted bursts with one list per observation point
  vaddr_pkg::lsu_req_t  exp_ax_q [$];
  vaddr_pkg::lsu_req_t  exp_lsu_q [$];
  int                   in_queue, errors, checks;
  string                test_name;
  integer               seed;
  logic [31:0]          rnd;

  vmem_addrgen #(
    .AxiDataWidth (AxiDataWidth),
    .QueueDepth   (QueueDepth)
  ) dut_i (
    .clk_i (clk), .rst_ni (rst_n), .req_i (req), .req_valid_i (req_valid),
    .ack_o (ack), .error_o (err),
    .ar_o (ar), .ar_valid_o (ar_valid), .ar_ready_i (ar_ready),
    .aw_o (aw), .aw_valid_o (aw_valid), .aw_ready_i (aw_ready),
    .lsu_req_o (lsu_req), .lsu_req_valid_o (lsu_valid),
    .ldu_ready_i (ldu_ready), .stu_ready_i (stu_ready)
  );

  always #2 clk = ~clk;

  // Random AXI slave readiness and an LSU hold that lets the queue fill
  always @(posedge clk) begin
    rnd = $random(seed);
    ar_ready  <= rnd[0] | rnd[1];
    aw_ready  <= rnd[2] | rnd[3];
    ldu_ready <= !lsu_hold && rnd[4];
    stu_ready <= !lsu_hold && (rnd[5] | rnd[6]);
  end

  task automatic check_value(input string what, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    assert (exp === act) else begin
      errors++;
      $display("ERROR %s %s: expected %0h, actual %0h", test_name, what, exp, act);
    end
  endtask

  // Burst rule applied to one unit-stride request
  task automatic plan_bursts(input longint addr, input longint n, input int ew_log,
                             input logic is_load);
    longint start, last, room, need, cnt, bend, used, esz;
    vaddr_pkg::lsu_req_t e;
    esz = longint'(1) << ew_log;
    while (n > 0) begin
      start = addr - (addr % BeatBytes);
      room  = (4096 - (start % 4096)) / BeatBytes;
      last  = addr + n * esz - 1;
      need  = (last - start) / BeatBytes + 1;
      cnt   = 256;
      if (room < cnt) begin
        cnt = room;
      end
      if (need < cnt) begin
        cnt = need;
      end
      bend = start + cnt * BeatBytes - 1;
      used = (bend + 1 - addr + esz - 1) / esz;
      if (used > n) begin
        used = n;
      end
      e.addr    = addr[31:0];
      e.len     = 8'(cnt - 1);
      e.size    = 3'($clog2(BeatBytes));
      e.is_load = is_load;
      exp_ax_q.push_back(e);
      exp_lsu_q.push_back(e);
      n    = n - used;
      addr = bend + 1;
    end
  endtask

  task automatic check_beat(input vaddr_pkg::axi_ax_t b, input logic on_ar);
    vaddr_pkg::lsu_req_t e;
    assert (exp_ax_q.size() > 0) else begin
      errors++;
      $display("AXI address beat at %0h arrived with no burst expected", b.addr);
    end
    if (exp_ax_q.size() > 0) begin
      e = exp_ax_q.pop_front();
      check_value("ax addr", e.addr, b.addr);
      check_value("ax len", e.len, b.len);
      check_value("ax size", e.size, b.size);
      check_value("ax channel is AR", e.is_load, on_ar);
      check_value("ax burst", 2'b01, b.burst);
      check_value("ax cache", 4'b0010, b.cache);
    end
  endtask

  task automatic check_pop(input vaddr_pkg::lsu_req_t act);
    vaddr_pkg::lsu_req_t e;
    assert (exp_lsu_q.size() > 0) else begin
      errors++;
      $display("Queue entry popped with nothing outstanding");
    end
    if (exp_lsu_q.size() > 0) begin
      e = exp_lsu_q.pop_front();
      check_value("pop addr", e.addr, act.addr);
      check_value("pop len", e.len, act.len);
      check_value("pop size", e.size, act.size);
      check_value("pop is_load", e.is_load, act.is_load);
    end
  endtask

  // Monitor that checks before it updates the queue occupancy
  always @(posedge clk) begin
    if (rst_n) begin
      if (in_queue == QueueDepth) begin
        assert (!ar_valid && !aw_valid) else begin
          errors++;
          $display("AXI valid was raised while the address queue was full");
        end
      end
      // Ack of a good instruction comes with its last burst
      if (ack && !err) begin
        checks++;
        assert (((ar_valid && ar_ready) || (aw_valid && aw_ready)) && exp_ax_q.size() == 1)
        else begin
          errors++;
          $display("ack_o in %s did not line up with the last burst", test_name);
        end
      end
      if ((ar_valid && ar_ready) || (aw_valid && aw_ready)) begin
        beat = ar_valid ? ar : aw;
        check_beat(beat, ar_valid);
        in_queue++;
      end
      if (lsu_valid && (ldu_ready || stu_ready)) begin
        check_pop(lsu_req);
        in_queue--;
      end
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n) err |-> ack)
    else begin
      errors++;
      $display("error_o was high without ack_o");
    end
  // The sequencer drops its request right after ack
  assert property (@(posedge clk) disable iff (!rst_n) ack |-> req_valid)
    else begin
      errors++;
      $display("ack_o was raised with no request held");
    end
  assert property (@(posedge clk) disable iff (!rst_n)
                   ar_valid && !ar_ready |=> ar_valid && $stable(ar))
    else begin
      errors++;
      $display("AR valid or payload changed before ready");
    end
  assert property (@(posedge clk) disable iff (!rst_n)
                   aw_valid && !aw_ready |=> aw_valid && $stable(aw))
    else begin
      errors++;
      $display("AW valid or payload changed before ready");
    end

  task automatic start_req(input int id, input vaddr_pkg::vop_e op, input logic [31:0] addr,
                           input logic [15:0] vl, input vaddr_pkg::vew_e vew,
                           input logic expect_err);
    @(posedge clk);
    if (!expect_err) begin
      plan_bursts(addr, vl, int'(vew), op == vaddr_pkg::OP_VLE);
    end
    req.id    <= vaddr_pkg::vid_t'(id);
    req.op    <= op;
    req.addr  <= addr;
    req.vl    <= vl;
    req.vew   <= vew;
    req_valid <= 1'b1;
  endtask

  task automatic wait_ack(input logic expect_err);
    int t;
    t = 0;
    do begin
      @(posedge clk);
      t++;
    end while (!ack && t < WaitLimit);
    if (!ack) begin
      errors++;
      $display("Timed out waiting for ack in %s", test_name);
    end else begin
      check_value("error_o", expect_err, err);
    end
    req_valid <= 1'b0;
  endtask

  task automatic wait_drain();
    int t;
    t = 0;
    while ((exp_ax_q.size() > 0 || exp_lsu_q.size() > 0) && t < WaitLimit) begin
      @(negedge clk);
      t++;
    end
    assert (exp_ax_q.size() == 0 && exp_lsu_q.size() == 0) else begin
      errors++;
      $display("Timed out in %s with bursts still outstanding", test_name);
    end
  endtask

  initial begin
    int t;
    clk = 1'b0;
    rst_n = 1'b0;
    req = '0;
    req.running = 8'hff;
    req_valid = 1'b0;
    ar_ready = 1'b0;
    aw_ready = 1'b0;
    ldu_ready = 1'b0;
    stu_ready = 1'b0;
    lsu_hold = 1'b0;
    in_queue = 0;
    errors = 0;
    checks = 0;
    seed = 32'hb0d6_45c6;
    test_name = "reset";
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    repeat (3) begin
      @(posedge clk);
      checks++;
      assert (!ar_valid && !aw_valid && !lsu_valid && !ack && !err) else begin
        errors++;
        $display("Outputs were not idle after reset");
      end
    end

    // Short load inside one page
    test_name = "load_one_page";
    start_req(0, vaddr_pkg::OP_VLE, 32'h1000_0104, 16'd20, vaddr_pkg::EW32, 1'b0);
    wait_ack(1'b0);
    wait_drain();

    // Page crossing store and then a load longer than 256 beats
    test_name = "store_page_cross";
    start_req(1, vaddr_pkg::OP_VSE, 32'h2000_0fc0, 16'd16, vaddr_pkg::EW64, 1'b0);
    wait_ack(1'b0);
    test_name = "load_long";
    start_req(2, vaddr_pkg::OP_VLE, 32'h3000_0000, 16'd1500, vaddr_pkg::EW16, 1'b0);
    wait_ack(1'b0);
    wait_drain();

    // LSUs frozen until the queue fills and AR stalls
    test_name = "queue_full";
    @(posedge clk);
    lsu_hold <= 1'b1;
    start_req(3, vaddr_pkg::OP_VLE, 32'h4000_0800, 16'd3000, vaddr_pkg::EW32, 1'b0);
    t = 0;
    while (in_queue < QueueDepth && t < WaitLimit) begin
      @(negedge clk);
      t++;
    end
    check_value("queue fill", QueueDepth, in_queue);
    repeat (10) begin
      @(negedge clk);
      checks++;
      assert (!ar_valid) else begin
        errors++;
        $display("AR valid stayed high with the queue full");
      end
    end
    @(posedge clk);
    lsu_hold <= 1'b0;
    wait_ack(1'b0);
    wait_drain();

    // Rejected requests
    test_name = "misaligned";
    start_req(4, vaddr_pkg::OP_VLE, 32'h5000_0002, 16'd8, vaddr_pkg::EW32, 1'b1);
    wait_ack(1'b1);
    test_name = "strided";
    start_req(5, vaddr_pkg::OP_VLSE, 32'h5000_0000, 16'd8, vaddr_pkg::EW32, 1'b1);
    wait_ack(1'b1);
    test_name = "indexed";
    start_req(6, vaddr_pkg::OP_VSXE, 32'h5000_0000, 16'd8, vaddr_pkg::EW64, 1'b1);
    wait_ack(1'b1);

    // Id 0 is still running until the sequencer clears its bit
    test_name = "running_id";
    start_req(0, vaddr_pkg::OP_VLE, 32'h6000_0010, 16'd12, vaddr_pkg::EW8, 1'b0);
    repeat (20) begin
      @(posedge clk);
      checks++;
      assert (!ack && !ar_valid) else begin
        errors++;
        $display("Request with a running id was started");
      end
    end
    req.running <= 8'hfe;
    wait_ack(1'b0);
    wait_drain();

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // Watchdog for the whole run
  initial begin
    #400000;
    $display("Watchdog expired before the test sequence finished");
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* vmem_addrgen.sv */
// Vector memory address generator, checks instructions and issues AXI address bursts
`timescale 1ns/1ps
`default_nettype none

module vmem_addrgen #(
  parameter int unsigned AxiDataWidth = 64,
  parameter int unsigned QueueDepth   = 4
) (
  input  wire                      clk_i,
  input  wire                      rst_ni,
  // Sequencer side
  input  vaddr_pkg::vmem_req_t     req_i,
  input  logic                     req_valid_i,
  output logic                     ack_o,
  output logic                     error_o,
  // AXI AR channel
  output vaddr_pkg::axi_ax_t       ar_o,
  output logic                     ar_valid_o,
  input  logic                     ar_ready_i,
  // AXI AW channel
  output vaddr_pkg::axi_ax_t       aw_o,
  output logic                     aw_valid_o,
  input  logic                     aw_ready_i,
  // Load/store unit side
  output vaddr_pkg::lsu_req_t      lsu_req_o,
  output logic                     lsu_req_valid_o,
  input  logic                     ldu_ready_i,
  input  logic                     stu_ready_i
);

  typedef enum logic {
    ADDRGEN_IDLE,
    ADDRGEN_BUSY
  } addrgen_state_e;

  addrgen_state_e                  state_d, state_q;
  logic [vaddr_pkg::NrVInsn-1:0]   running_d, running_q;

  // Splitter handshake
  vaddr_pkg::split_req_t           split_req;
  logic                            split_start;
  logic                            split_done;

  // Queue wiring
  vaddr_pkg::lsu_req_t             queue_data;
  logic                            queue_push;
  logic                            queue_full;
  logic                            queue_empty;

  // Instruction checks
  logic                            misaligned;
  logic                            unsupported;

  // Base address must sit on an element boundary
  assign misaligned  = |(req_i.addr & ((vaddr_pkg::addr_t'(1) << req_i.vew) - 1'b1));
  // Only unit-stride makes it to the splitter
  assign unsupported = !(req_i.op inside {vaddr_pkg::OP_VLE, vaddr_pkg::OP_VSE});

  always_comb begin
    split_req         = '0;
    split_req.addr    = req_i.addr;
    split_req.len     = req_i.vl;
    split_req.vew     = req_i.vew;
    split_req.is_load = (req_i.op == vaddr_pkg::OP_VLE);
  end

  always_comb begin
    state_d     = state_q;
    // Ids drop out once the sequencer retires them
    running_d   = running_q & req_i.running;
    split_start = 1'b0;
    ack_o       = 1'b0;
    error_o     = 1'b0;

    case (state_q)
      ADDRGEN_IDLE: begin
        if (req_valid_i && !running_q[req_i.id]) begin
          running_d[req_i.id] = 1'b1;
          if (misaligned || unsupported) begin
            // Rejected, no burst
            ack_o   = 1'b1;
            error_o = 1'b1;
          end else if (req_i.vl == '0) begin
            // Nothing to move
            ack_o = 1'b1;
          end else begin
            split_start = 1'b1;
            state_d     = ADDRGEN_BUSY;
          end
        end
      end
      ADDRGEN_BUSY: begin
        // Ack lines up with the last AXI handshake
        if (split_done) begin
          ack_o   = 1'b1;
          state_d = ADDRGEN_IDLE;
        end
      end
      default: state_d = ADDRGEN_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= ADDRGEN_IDLE;
      running_q <= '0;
    end else begin
      state_q   <= state_d;
      running_q <= running_d;
    end
  end

  burst_splitter #(
    .AxiDataWidth (AxiDataWidth)
  ) i_burst_splitter (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_i        (split_req),
    .start_i      (split_start),
    .done_o       (split_done),
    .ar_o         (ar_o),
    .ar_valid_o   (ar_valid_o),
    .ar_ready_i   (ar_ready_i),
    .aw_o         (aw_o),
    .aw_valid_o   (aw_valid_o),
    .aw_ready_i   (aw_ready_i),
    .push_o       (queue_push),
    .lsu_req_o    (queue_data),
    .queue_full_i (queue_full)
  );

  // Either unit may take the head entry
  addr_queue #(
    .Depth   (QueueDepth),
    .dtype   (vaddr_pkg::lsu_req_t)
  ) i_addr_queue (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .data_i  (queue_data),
    .push_i  (queue_push),
    .full_o  (queue_full),
    .data_o  (lsu_req_o),
    .pop_i   (ldu_ready_i | stu_ready_i),
    .empty_o (queue_empty)
  );

  assign lsu_req_valid_o = !queue_empty;

endmodule

`default_nettype wire

/* burst_splitter.sv */
// Burst splitter that cuts a unit-stride request into page-safe AXI INCR bursts
`timescale 1ns/1ps
`default_nettype none

module burst_splitter #(
  parameter int unsigned AxiDataWidth = 64
) (
  input  wire                     clk_i,
  input  wire                     rst_ni,
  // Request from the top level
  input  vaddr_pkg::split_req_t   req_i,
  input  logic                    start_i,
  output logic                    done_o,
  // AXI AR channel
  output vaddr_pkg::axi_ax_t      ar_o,
  output logic                    ar_valid_o,
  input  logic                    ar_ready_i,
  // AXI AW channel
  output vaddr_pkg::axi_ax_t      aw_o,
  output logic                    aw_valid_o,
  input  logic                    aw_ready_i,
  // Address queue write side
  output logic                    push_o,
  output vaddr_pkg::lsu_req_t     lsu_req_o,
  input  logic                    queue_full_i
);

  // Bytes per beat and its log
  localparam int unsigned BeatBytes = AxiDataWidth / 8;
  localparam int unsigned SizeLog   = $clog2(BeatBytes);
  // 4 KiB page
  localparam int unsigned PageBits  = 12;
  localparam int unsigned PageBytes = 1 << PageBits;

  typedef enum logic {
    SPLIT_IDLE,
    SPLIT_REQ
  } split_state_e;

  split_state_e          state_d, state_q;
  vaddr_pkg::split_req_t req_d, req_q;

  // Burst rule datapath
  vaddr_pkg::addr_t  aligned_start;
  vaddr_pkg::addr_t  byte_count;
  vaddr_pkg::addr_t  last_byte;
  vaddr_pkg::addr_t  need_beats;
  vaddr_pkg::addr_t  burst_end;
  vaddr_pkg::addr_t  next_addr;
  vaddr_pkg::addr_t  elem_mask;
  vaddr_pkg::addr_t  consumed;
  logic [PageBits:0] page_beats;
  logic [8:0]        beat_cnt;
  vaddr_pkg::vlen_t  len_next;
  vaddr_pkg::axi_ax_t ax;
  logic              ax_ready;

  always_comb begin
    // First beat boundary at or below the current address
    aligned_start = req_q.addr & ~vaddr_pkg::addr_t'(BeatBytes - 1);
    byte_count    = vaddr_pkg::addr_t'(req_q.len) << req_q.vew;
    last_byte     = req_q.addr + byte_count - 1'b1;

    // Beats left before the page boundary
    page_beats = ((PageBits + 1)'(PageBytes) - {1'b0, aligned_start[PageBits-1:0]}) >> SizeLog;
    // Beats needed to cover the last byte
    need_beats = ((last_byte - aligned_start) >> SizeLog) + 1'b1;

    // Least of 256, page room and what is left
    beat_cnt = 9'd256;
    if ({4'b0, beat_cnt} > page_beats) begin
      beat_cnt = page_beats[8:0];
    end
    if (need_beats < vaddr_pkg::addr_t'(beat_cnt)) begin
      beat_cnt = need_beats[8:0];
    end

    burst_end = aligned_start + (vaddr_pkg::addr_t'(beat_cnt) << SizeLog) - 1'b1;
    next_addr = burst_end + 1'b1;

    // Elements covered rounded up
    elem_mask = (vaddr_pkg::addr_t'(1) << req_q.vew) - 1'b1;
    consumed  = (next_addr - req_q.addr + elem_mask) >> req_q.vew;
    if (consumed >= vaddr_pkg::addr_t'(req_q.len)) begin
      len_next = '0;
    end else begin
      len_next = req_q.len - vaddr_pkg::vlen_t'(consumed);
    end
  end

  // Beat carries the unaligned address
  always_comb begin
    ax       = '0;
    ax.addr  = req_q.addr;
    ax.len   = 8'(beat_cnt - 9'd1);
    ax.size  = 3'(SizeLog);
    ax.burst = vaddr_pkg::BurstIncr;
    ax.cache = vaddr_pkg::CacheModifiable;
  end

  // Same payload on both channels and valid selects the one in use
  assign ar_o = ax;
  assign aw_o = ax;

  always_comb begin
    lsu_req_o         = '0;
    lsu_req_o.addr    = ax.addr;
    lsu_req_o.len     = ax.len;
    lsu_req_o.size    = ax.size;
    lsu_req_o.is_load = req_q.is_load;
  end

  assign ax_ready = req_q.is_load ? ar_ready_i : aw_ready_i;

  always_comb begin
    state_d    = state_q;
    req_d      = req_q;
    done_o     = 1'b0;
    push_o     = 1'b0;
    ar_valid_o = 1'b0;
    aw_valid_o = 1'b0;

    case (state_q)
      SPLIT_IDLE: begin
        // Latch the request and raise the first beat next cycle
        if (start_i) begin
          req_d   = req_i;
          state_d = SPLIT_REQ;
        end
      end
      SPLIT_REQ: begin
        // Hold back while the queue has no room
        if (!queue_full_i) begin
          ar_valid_o = req_q.is_load;
          aw_valid_o = !req_q.is_load;
          if (ax_ready) begin
            // On handshake queue the descriptor and advance
            push_o     = 1'b1;
            req_d.addr = next_addr;
            req_d.len  = len_next;
            if (len_next == '0) begin
              done_o  = 1'b1;
              state_d = SPLIT_IDLE;
            end
          end
        end
      end
      default: state_d = SPLIT_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= SPLIT_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Working request with the running address and remaining length
  always_ff @(posedge clk_i) begin
    req_q <= req_d;
  end

endmodule

`default_nettype wire

/* addr_queue.sv */
// Address queue as a small circular-buffer FIFO of burst descriptors
`timescale 1ns/1ps
`default_nettype none

module addr_queue #(
  parameter int unsigned Depth = 4,
  parameter type         dtype = logic
) (
  input  wire  clk_i,
  input  wire  rst_ni,
  // Write side
  input  dtype data_i,
  input  logic push_i,
  output logic full_o,
  // Read side
  output dtype data_o,
  input  logic pop_i,
  output logic empty_o
);

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntWidth = $clog2(Depth + 1);

  // Entry storage
  dtype mem_q [Depth];

  logic [PtrWidth-1:0] wr_ptr_q, rd_ptr_q;
  logic [CntWidth-1:0] cnt_q;
  logic                push_ok, pop_ok;

  assign full_o  = (cnt_q == CntWidth'(Depth));
  assign empty_o = (cnt_q == '0);

  // Push on full and pop on empty are dropped
  assign push_ok = push_i && !full_o;
  assign pop_ok  = pop_i && !empty_o;

  // Head of queue
  assign data_o = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Occupancy stays put on simultaneous push and pop
      case ({push_ok, pop_ok})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_ok) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

`default_nettype wire

/* vaddr_pkg.sv */
// Vector memory address generator package with widths, opcodes and channel structs
`default_nettype none

package vaddr_pkg;

  // AXI address width
  localparam int unsigned AddrWidth = 32;
  // Number of instruction ids tracked by the sequencer
  localparam int unsigned NrVInsn   = 8;

  // AXI encodings used by the splitter
  localparam logic [1:0] BurstIncr       = 2'b01;
  localparam logic [3:0] CacheModifiable = 4'b0010;

  typedef logic [AddrWidth-1:0]       addr_t;
  typedef logic [$clog2(NrVInsn)-1:0] vid_t;
  // Vector length in elements
  typedef logic [15:0]                vlen_t;

  // Vector memory opcodes
  // Only the unit-stride pair is split into bursts
  typedef enum logic [2:0] {
    OP_VLE,
    OP_VSE,
    OP_VLSE,
    OP_VSSE,
    OP_VLXE,
    OP_VSXE
  } vop_e;

  // Element width, value is log2 of the width in bytes
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  // Instruction as presented by the sequencer
  typedef struct packed {
    vid_t               id;
    vop_e               op;
    addr_t              addr;
    vlen_t              vl;
    vew_e               vew;
    // One bit per id still live in the sequencer
    logic [NrVInsn-1:0] running;
  } vmem_req_t;

  // Work item for the burst splitter
  typedef struct packed {
    addr_t addr;
    vlen_t len;
    vew_e  vew;
    logic  is_load;
  } split_req_t;

  // AXI AR/AW beat
  typedef struct packed {
    addr_t      addr;
    logic [7:0] len;
    logic [2:0] size;
    logic [1:0] burst;
    logic [3:0] cache;
  } axi_ax_t;

  // Burst descriptor for the load/store units
  typedef struct packed {
    addr_t      addr;
    logic [7:0] len;
    logic [2:0] size;
    logic       is_load;
  } lsu_req_t;

endpackage

`default_nettype wire
